// ==== rtl/vliw_core_pkg.sv ====
package vliw_core_pkg;

  localparam int LANES     = 4;                  // Instructions per packet
  localparam int XLEN      = 32;                 // Datapath width
  localparam int REG_IDX_W = 5;                  // Register number width
  localparam int NUM_REGS  = 1 << REG_IDX_W;     // 32 architectural registers
  localparam int PADDR_W   = 28;                 // Packet address width
  localparam int PACKET_W  = LANES * XLEN;       // Lane i at bits 32i+31:32i

  localparam int OP_W      = 4;
  localparam int SHTYPE_W  = 2;
  localparam int SHAMT_W   = 5;
  localparam int IMM_W     = 18;

  // Opcodes, anything else is undefined and retires as a bubble
  localparam logic [OP_W-1:0] OP_NOP  = 4'd0;
  localparam logic [OP_W-1:0] OP_ADD  = 4'd1;
  localparam logic [OP_W-1:0] OP_SUB  = 4'd2;
  localparam logic [OP_W-1:0] OP_AND  = 4'd3;
  localparam logic [OP_W-1:0] OP_OR   = 4'd4;
  localparam logic [OP_W-1:0] OP_XOR  = 4'd5;
  localparam logic [OP_W-1:0] OP_ADDI = 4'd8;

  // Shift applied to the rt operand
  localparam logic [SHTYPE_W-1:0] SH_LSL = 2'd0;
  localparam logic [SHTYPE_W-1:0] SH_LSR = 2'd1;
  localparam logic [SHTYPE_W-1:0] SH_ASR = 2'd2;
  localparam logic [SHTYPE_W-1:0] SH_ROR = 2'd3;

  // One instruction word, op picks the view
  typedef union packed {
    struct packed {
      logic [OP_W-1:0]      op;
      logic [REG_IDX_W-1:0] rd;
      logic [REG_IDX_W-1:0] rs;
      logic [REG_IDX_W-1:0] rt;
      logic [SHTYPE_W-1:0]  shift_type;
      logic [SHAMT_W-1:0]   shift_amount;
      logic [5:0]           unused;       // Reserved, ignored by decode
    } r;                                  // Register form
    struct packed {
      logic [OP_W-1:0]         op;
      logic [REG_IDX_W-1:0]    rd;
      logic [REG_IDX_W-1:0]    rs;
      logic signed [IMM_W-1:0] imm;
    } i;                                  // Immediate form, ADDI only
  } instr_t;

endpackage

// ==== rtl/vliw_fetch.sv ====
module vliw_fetch import vliw_core_pkg::*; (
  input  logic                clkrst_core_clk,
  input  logic                arst_n,
  input  logic [PACKET_W-1:0] ic_packet,
  input  logic                ic_ready,
  input  logic                dec_ready,
  output logic [PADDR_W-1:0]  ic_paddr,
  output logic                ic_valid,
  output logic                dec_valid,
  output logic [PACKET_W-1:0] dec_packet
);

  logic req_on;   // Set one cycle after reset release
  logic f_accept; // Fetch register empty or draining
  logic ic_xfer;

  assign f_accept = ~dec_valid | dec_ready;
  assign ic_valid = req_on & f_accept;       // Drops only while the register is stuck
  assign ic_xfer  = ic_valid & ic_ready;

  always_ff @(posedge clkrst_core_clk or negedge arst_n) begin
    if (!arst_n) begin
      req_on    <= 1'b0;
      ic_paddr  <= '0;                       // Packet counter starts at 0
      dec_valid <= 1'b0;
    end else begin
      req_on <= 1'b1;
      if (ic_xfer) begin
        ic_paddr <= ic_paddr + 1'b1;         // One packet per transfer
      end
      if (f_accept) begin
        dec_valid <= ic_xfer;
      end
    end
  end

  // Packet payload, captured on the cache transfer
  always_ff @(posedge clkrst_core_clk) begin
    if (ic_xfer) begin
      dec_packet <= ic_packet;
    end
  end

endmodule

// ==== rtl/vliw_lane_decode.sv ====
module vliw_lane_decode import vliw_core_pkg::*; (
  input  instr_t               inst,
  output logic [REG_IDX_W-1:0] rs_num,
  output logic [REG_IDX_W-1:0] rt_num,
  output logic [REG_IDX_W-1:0] rd_num,
  output logic                 rd_we,
  output logic                 use_imm,
  output logic [XLEN-1:0]      imm,
  output logic [OP_W-1:0]      alu_op,
  output logic [SHTYPE_W-1:0]  shift_type,
  output logic [SHAMT_W-1:0]   shift_amount
);

  // Unused sources read r0, which is never busy
  always_comb begin
    rs_num       = '0;
    rt_num       = '0;
    rd_num       = inst.r.rd;             // Same position in both views
    rd_we        = 1'b0;
    use_imm      = 1'b0;
    imm          = {{(XLEN-IMM_W){inst.i.imm[IMM_W-1]}}, inst.i.imm}; // Sign extend
    alu_op       = inst.r.op;
    shift_type   = inst.r.shift_type;
    shift_amount = inst.r.shift_amount;
    case (inst.r.op)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
        rs_num = inst.r.rs;
        rt_num = inst.r.rt;
        rd_we  = 1'b1;
      end
      OP_ADDI: begin
        rs_num  = inst.i.rs;              // Immediate view, rt slot is imm
        use_imm = 1'b1;
        rd_we   = 1'b1;
      end
      OP_NOP: rd_we = 1'b0;               // Bubble lane
      default: rd_we = 1'b0;              // Undefined opcode writes nothing
    endcase
    if (rd_num == '0) begin
      rd_we = 1'b0;                       // r0 is read only
    end
  end

endmodule

// ==== rtl/vliw_issue.sv ====
module vliw_issue import vliw_core_pkg::*; (
  input  logic                                clkrst_core_clk,
  input  logic                                arst_n,
  input  logic                                dec_valid,
  input  logic [PACKET_W-1:0]                 dec_packet,
  input  logic [NUM_REGS-1:0]                 busy,
  input  logic [LANES-1:0][XLEN-1:0]          rs_data,
  input  logic [LANES-1:0][XLEN-1:0]          rt_data,
  input  logic                                ex_ready,
  output logic                                dec_ready,
  output logic [LANES-1:0][REG_IDX_W-1:0]     rs_num,
  output logic [LANES-1:0][REG_IDX_W-1:0]     rt_num,
  output logic                                issue_fire,
  output logic [LANES-1:0][REG_IDX_W-1:0]     issue_rd_num,
  output logic [LANES-1:0]                    issue_rd_we,
  output logic                                ex_valid,
  output logic [LANES-1:0][XLEN-1:0]          ex_rs_data,
  output logic [LANES-1:0][XLEN-1:0]          ex_rt_data,
  output logic [LANES-1:0]                    ex_use_imm,
  output logic [LANES-1:0][XLEN-1:0]          ex_imm,
  output logic [LANES-1:0][OP_W-1:0]          ex_alu_op,
  output logic [LANES-1:0][SHTYPE_W-1:0]      ex_shift_type,
  output logic [LANES-1:0][SHAMT_W-1:0]       ex_shift_amount,
  output logic [LANES-1:0][REG_IDX_W-1:0]     ex_rd_num,
  output logic [LANES-1:0]                    ex_rd_we
);

  logic [LANES-1:0]               d_use_imm;
  logic [LANES-1:0][XLEN-1:0]     d_imm;
  logic [LANES-1:0][OP_W-1:0]     d_alu_op;
  logic [LANES-1:0][SHTYPE_W-1:0] d_shift_type;
  logic [LANES-1:0][SHAMT_W-1:0]  d_shift_amount;
  logic                           dep_stall;

  for (genvar l = 0; l < LANES; l++) begin : g_lane
    vliw_lane_decode u_dec (
      .inst         (instr_t'(dec_packet[l*XLEN +: XLEN])),
      .rs_num       (rs_num[l]),
      .rt_num       (rt_num[l]),
      .rd_num       (issue_rd_num[l]),
      .rd_we        (issue_rd_we[l]),
      .use_imm      (d_use_imm[l]),
      .imm          (d_imm[l]),
      .alu_op       (d_alu_op[l]),
      .shift_type   (d_shift_type[l]),
      .shift_amount (d_shift_amount[l])
    );
  end

  // Any pending source or destination holds the whole packet
  always_comb begin
    dep_stall = 1'b0;
    for (int l = 0; l < LANES; l++) begin
      if (busy[rs_num[l]] || busy[rt_num[l]]) dep_stall = 1'b1;
      if (issue_rd_we[l] && busy[issue_rd_num[l]]) dep_stall = 1'b1;
    end
  end

  assign dec_ready  = ~dep_stall & (~ex_valid | ex_ready);
  assign issue_fire = dec_valid & dec_ready;

  always_ff @(posedge clkrst_core_clk or negedge arst_n) begin
    if (!arst_n) ex_valid <= 1'b0;
    else if (~ex_valid | ex_ready) ex_valid <= issue_fire;
  end

  // Operands and controls, only meaningful with ex_valid
  always_ff @(posedge clkrst_core_clk) begin
    if (issue_fire) begin
      ex_rs_data      <= rs_data;            // Values from before this packet
      ex_rt_data      <= rt_data;
      ex_use_imm      <= d_use_imm;
      ex_imm          <= d_imm;
      ex_alu_op       <= d_alu_op;
      ex_shift_type   <= d_shift_type;
      ex_shift_amount <= d_shift_amount;
      ex_rd_num       <= issue_rd_num;
      ex_rd_we        <= issue_rd_we;
    end
  end

endmodule

// ==== rtl/vliw_scoreboard.sv ====
module vliw_scoreboard import vliw_core_pkg::*; (
  input  logic                            clkrst_core_clk,
  input  logic                            arst_n,
  input  logic                            issue_fire,
  input  logic [LANES-1:0][REG_IDX_W-1:0] issue_rd_num,
  input  logic [LANES-1:0]                issue_rd_we,
  input  logic                            retire_valid,
  input  logic [LANES-1:0][REG_IDX_W-1:0] retire_rd_num,
  input  logic [LANES-1:0]                retire_we,
  output logic [NUM_REGS-1:0]             busy
);

  // Set after clear, so a reissued register stays busy
  always_ff @(posedge clkrst_core_clk or negedge arst_n) begin
    if (!arst_n) begin
      busy <= '0;
    end else begin
      for (int l = 0; l < LANES; l++) begin
        if (retire_valid && retire_we[l]) begin
          busy[retire_rd_num[l]] <= 1'b0;  // Result lands in the regfile now
        end
      end
      for (int l = 0; l < LANES; l++) begin
        if (issue_fire && issue_rd_we[l]) begin
          busy[issue_rd_num[l]] <= 1'b1;   // rd_we is never set for r0
        end
      end
    end
  end

endmodule

// ==== rtl/vliw_regfile.sv ====
module vliw_regfile import vliw_core_pkg::*; (
  input  logic                            clkrst_core_clk,
  input  logic                            arst_n,
  input  logic [LANES-1:0][REG_IDX_W-1:0] rs_num,
  input  logic [LANES-1:0][REG_IDX_W-1:0] rt_num,
  input  logic [LANES-1:0]                wr_en,
  input  logic [LANES-1:0][REG_IDX_W-1:0] wr_num,
  input  logic [LANES-1:0][XLEN-1:0]      wr_data,
  output logic [LANES-1:0][XLEN-1:0]      rs_data,
  output logic [LANES-1:0][XLEN-1:0]      rt_data
);

  logic [XLEN-1:0] regs [NUM_REGS];

  // Lanes in ascending order, the highest lane lands last
  always_ff @(posedge clkrst_core_clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      for (int l = 0; l < LANES; l++) begin
        if (wr_en[l] && wr_num[l] != '0) begin
          regs[wr_num[l]] <= wr_data[l];   // Entry 0 keeps its reset zero
        end
      end
    end
  end

  // Eight combinational read ports
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      rs_data[l] = regs[rs_num[l]];
      rt_data[l] = regs[rt_num[l]];
    end
  end

endmodule

// ==== rtl/vliw_alu.sv ====
module vliw_alu import vliw_core_pkg::*; (
  input  logic [XLEN-1:0]     op_a,
  input  logic [XLEN-1:0]     op_b,
  input  logic                use_imm,
  input  logic [XLEN-1:0]     imm,
  input  logic [OP_W-1:0]     alu_op,
  input  logic [SHTYPE_W-1:0] shift_type,
  input  logic [SHAMT_W-1:0]  shift_amount,
  output logic [XLEN-1:0]     result
);

  logic [2*XLEN-1:0] rot_full; // Doubled word for rotate
  logic [XLEN-1:0]   shifted;
  logic [XLEN-1:0]   op2;

  assign rot_full = {op_b, op_b} >> shift_amount;

  always_comb begin
    case (shift_type)
      SH_LSL:  shifted = op_b << shift_amount;
      SH_LSR:  shifted = op_b >> shift_amount;
      SH_ASR:  shifted = $signed(op_b) >>> shift_amount; // Sign fill
      SH_ROR:  shifted = rot_full[XLEN-1:0];
      default: shifted = op_b;
    endcase
  end

  assign op2 = use_imm ? imm : shifted;

  always_comb begin
    case (alu_op)
      OP_ADD, OP_ADDI: result = op_a + op2;
      OP_SUB:          result = op_a - op2;
      OP_AND:          result = op_a & op2;
      OP_OR:           result = op_a | op2;
      OP_XOR:          result = op_a ^ op2;
      default:         result = '0;        // NOP, write enable is off anyway
    endcase
  end

endmodule

// ==== rtl/vliw_execute.sv ====
module vliw_execute import vliw_core_pkg::*; (
  input  logic                            clkrst_core_clk,
  input  logic                            arst_n,
  input  logic                            ex_valid,
  input  logic [LANES-1:0][XLEN-1:0]      ex_rs_data,
  input  logic [LANES-1:0][XLEN-1:0]      ex_rt_data,
  input  logic [LANES-1:0]                ex_use_imm,
  input  logic [LANES-1:0][XLEN-1:0]      ex_imm,
  input  logic [LANES-1:0][OP_W-1:0]      ex_alu_op,
  input  logic [LANES-1:0][SHTYPE_W-1:0]  ex_shift_type,
  input  logic [LANES-1:0][SHAMT_W-1:0]   ex_shift_amount,
  input  logic [LANES-1:0][REG_IDX_W-1:0] ex_rd_num,
  input  logic [LANES-1:0]                ex_rd_we,
  output logic                            ex_ready,
  output logic                            retire_valid,
  output logic [LANES-1:0]                retire_we,
  output logic [LANES-1:0][REG_IDX_W-1:0] retire_rd_num,
  output logic [LANES-1:0][XLEN-1:0]      retire_rd_data
);

  logic [LANES-1:0][XLEN-1:0] alu_result;

  for (genvar l = 0; l < LANES; l++) begin : g_alu
    vliw_alu u_alu (
      .op_a         (ex_rs_data[l]),
      .op_b         (ex_rt_data[l]),
      .use_imm      (ex_use_imm[l]),
      .imm          (ex_imm[l]),
      .alu_op       (ex_alu_op[l]),
      .shift_type   (ex_shift_type[l]),
      .shift_amount (ex_shift_amount[l]),
      .result       (alu_result[l])
    );
  end

  assign ex_ready = 1'b1; // Writeback never stalls

  always_ff @(posedge clkrst_core_clk or negedge arst_n) begin
    if (!arst_n) begin
      retire_valid <= 1'b0;
      retire_we    <= '0;
    end else begin
      retire_valid <= ex_valid;
      retire_we    <= ex_valid ? ex_rd_we : '0; // No stray writes from bubbles
    end
  end

  always_ff @(posedge clkrst_core_clk) begin
    retire_rd_num  <= ex_rd_num;
    retire_rd_data <= alu_result;
  end

endmodule

// ==== rtl/vliw_core.sv ====
module vliw_core import vliw_core_pkg::*; (
  input  logic                            clkrst_core_clk,
  input  logic                            arst_n,
  output logic [PADDR_W-1:0]              ic_paddr,
  output logic                            ic_valid,
  input  logic [PACKET_W-1:0]             ic_packet,
  input  logic                            ic_ready,
  output logic                            retire_valid,
  output logic [LANES-1:0]                retire_we,
  output logic [LANES-1:0][REG_IDX_W-1:0] retire_rd_num,
  output logic [LANES-1:0][XLEN-1:0]      retire_rd_data
);

  // Fetch to issue
  logic                dec_valid;
  logic                dec_ready;
  logic [PACKET_W-1:0] dec_packet;

  // Issue side register file and scoreboard
  logic [LANES-1:0][REG_IDX_W-1:0] rs_num, rt_num;
  logic [LANES-1:0][XLEN-1:0]      rs_data, rt_data;
  logic [NUM_REGS-1:0]             busy;
  logic                            issue_fire;
  logic [LANES-1:0][REG_IDX_W-1:0] issue_rd_num;
  logic [LANES-1:0]                issue_rd_we;

  // Issue to execute
  logic                            ex_valid, ex_ready;
  logic [LANES-1:0][XLEN-1:0]      ex_rs_data, ex_rt_data, ex_imm;
  logic [LANES-1:0]                ex_use_imm, ex_rd_we;
  logic [LANES-1:0][OP_W-1:0]      ex_alu_op;
  logic [LANES-1:0][SHTYPE_W-1:0]  ex_shift_type;
  logic [LANES-1:0][SHAMT_W-1:0]   ex_shift_amount;
  logic [LANES-1:0][REG_IDX_W-1:0] ex_rd_num;

  vliw_fetch u_fetch (.*);

  vliw_issue u_issue (.*);

  vliw_scoreboard u_sb (.*);

  // Retire bus doubles as the write port
  vliw_regfile u_regs (
    .clkrst_core_clk (clkrst_core_clk),
    .arst_n          (arst_n),
    .rs_num          (rs_num),
    .rt_num          (rt_num),
    .wr_en           (retire_we),
    .wr_num          (retire_rd_num),
    .wr_data         (retire_rd_data),
    .rs_data         (rs_data),
    .rt_data         (rt_data)
  );

  vliw_execute u_exec (.*);

endmodule

// ==== tests/vliw_core_props.sv ====
module vliw_core_props import vliw_core_pkg::*; (
  input logic                clkrst_core_clk,
  input logic                arst_n,
  input logic [PADDR_W-1:0]  ic_paddr,
  input logic                ic_valid,
  input logic                ic_ready,
  input logic                retire_valid,
  input logic [LANES-1:0]    retire_we
);

  // Pending request keeps its address
  paddr_stable: assert property (@(posedge clkrst_core_clk) disable iff (!arst_n)
    ic_valid && !ic_ready |=> $stable(ic_paddr))
    else $error("ic_paddr moved while a cache request was pending");

  no_retire_in_reset: assert property (@(posedge clkrst_core_clk) !arst_n |-> !retire_valid)
    else $error("retire_valid high during reset");

  no_request_in_reset: assert property (@(posedge clkrst_core_clk) !arst_n |-> !ic_valid)
    else $error("ic_valid high during reset");

  // Write enables only on a retire cycle
  we_needs_valid: assert property (@(posedge clkrst_core_clk) disable iff (!arst_n)
    retire_we != '0 |-> retire_valid)
    else $error("retire_we set without retire_valid");

endmodule

bind vliw_core vliw_core_props u_props (
  .clkrst_core_clk (clkrst_core_clk),
  .arst_n          (arst_n),
  .ic_paddr        (ic_paddr),
  .ic_valid        (ic_valid),
  .ic_ready        (ic_ready),
  .retire_valid    (retire_valid),
  .retire_we       (retire_we)
);

// ==== tests/vliw_core_tb.sv ====
module vliw_core_tb import vliw_core_pkg::*; ();

  localparam int PERIOD     = 40;
  localparam int RESET_CYC  = 16;
  localparam int TOTAL_PKTS = 29;                      // All programs together
  localparam int WATCHDOG_T = (TOTAL_PKTS * 40 + 6 * (RESET_CYC + 4)) * PERIOD * 3;

  logic                            clkrst_core_clk;
  logic                            arst_n;
  logic [PADDR_W-1:0]              ic_paddr;
  logic                            ic_valid;
  logic [PACKET_W-1:0]             ic_packet;
  logic                            ic_ready;
  logic                            retire_valid;
  logic [LANES-1:0]                retire_we;
  logic [LANES-1:0][REG_IDX_W-1:0] retire_rd_num;
  logic [LANES-1:0][XLEN-1:0]      retire_rd_data;

  logic [PACKET_W-1:0] prog [32];
  logic [XLEN-1:0]     model_regs [NUM_REGS];
  logic [151:0]        exp_q [$];                      // {we, rd numbers, data} per packet
  int                  prog_len;
  int                  fetch_idx;
  int                  base_retired;                   // Retire count at test start
  int                  total_retired;
  int                  errors;
  bit                  random_ready;
  logic [31:0]         lfsr;

  vliw_core vliw_core_inst (.*);

  always #(PERIOD / 2) clkrst_core_clk = ~clkrst_core_clk;

  initial begin
    #(WATCHDOG_T);
    $display("Watchdog fired at %0t, packets stopped retiring", $time);
    $display("Test failed");
    $finish;
  end

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // Taps 32 22 2 1
  endfunction

  function automatic logic [31:0] enc_r(input logic [3:0] op, input int rd, rs, rt,
                                        input logic [1:0] sh, input int amt);
    return {op, 5'(rd), 5'(rs), 5'(rt), sh, 5'(amt), 6'd0};
  endfunction

  function automatic logic [31:0] enc_i(input int rd, rs, imm);
    return {OP_ADDI, 5'(rd), 5'(rs), 18'(imm)};
  endfunction

  function automatic logic [31:0] shift_val(input logic [31:0] v, input logic [1:0] t,
                                            input int n);
    case (t)
      SH_LSL:  return v << n;
      SH_LSR:  return v >> n;
      SH_ASR:  return $signed(v) >>> n;
      default: return (v >> n) | (v << (32 - n));     // Rotate, n = 0 keeps v
    endcase
  endfunction

  // Golden model, every lane sees the registers from before the packet
  task automatic add_packet(input logic [31:0] l0, l1, l2, l3);
    logic [PACKET_W-1:0]             pkt;
    logic [LANES-1:0]                we;
    logic [LANES-1:0][REG_IDX_W-1:0] rd;
    logic [LANES-1:0][XLEN-1:0]      res;
    logic [XLEN-1:0]                 a;
    logic [XLEN-1:0]                 b;
    instr_t                          w;
    pkt = {l3, l2, l1, l0};
    for (int l = 0; l < LANES; l++) begin
      w      = pkt[l*XLEN +: XLEN];
      a      = model_regs[w.r.rs];                    // rs sits alike in both views
      b      = shift_val(model_regs[w.r.rt], w.r.shift_type, int'(w.r.shift_amount));
      rd[l]  = w.r.rd;
      we[l]  = (w.r.rd != '0);                        // r0 never written
      res[l] = '0;
      case (w.r.op)
        OP_ADD:  res[l] = a + b;
        OP_SUB:  res[l] = a - b;
        OP_AND:  res[l] = a & b;
        OP_OR:   res[l] = a | b;
        OP_XOR:  res[l] = a ^ b;
        OP_ADDI: res[l] = a + XLEN'($signed(w.i.imm)); // Sign extended
        default: we[l] = 1'b0;                        // NOP or undefined
      endcase
    end
    for (int l = 0; l < LANES; l++) begin
      if (we[l]) begin
        model_regs[rd[l]] = res[l];                   // Higher lane lands last
      end
    end
    prog[prog_len] = pkt;
    prog_len++;
    exp_q.push_back({we, rd, res});
  endtask

  // Cache model, next packet goes out at the edge that ends a transfer
  always @(posedge clkrst_core_clk) begin
    if (!arst_n) begin
      fetch_idx = 0;
    end else if (ic_valid && ic_ready) begin
      check("ic_paddr", 128'(ic_paddr), 128'(fetch_idx));
      fetch_idx++;
    end
    // Past the program, undefined opcode tagged with the address
    ic_packet <= (fetch_idx < prog_len) ? prog[fetch_idx] : {LANES{4'hf, 28'(fetch_idx)}};
    if (random_ready) begin
      lfsr = lfsr_step(lfsr);
      ic_ready <= lfsr[0];
    end else begin
      ic_ready <= 1'b1;
    end
  end

  // Retire monitor, packets in fetch order
  always @(posedge clkrst_core_clk) begin
    logic [LANES-1:0]                e_we;
    logic [LANES-1:0][REG_IDX_W-1:0] e_rd;
    logic [LANES-1:0][XLEN-1:0]      e_data;
    if (arst_n && retire_valid && exp_q.size() == 0) begin
      check("retire_we", 128'(retire_we), 128'(0));  // Filler after the program
    end else if (arst_n && retire_valid) begin
      {e_we, e_rd, e_data} = exp_q.pop_front();
      check("retire_we", 128'(retire_we), 128'(e_we));
      for (int l = 0; l < LANES; l++) begin
        if (e_we[l]) begin
          check($sformatf("retire_rd_num[%0d]", l), 128'(retire_rd_num[l]), 128'(e_rd[l]));
          check($sformatf("retire_rd_data[%0d]", l), 128'(retire_rd_data[l]), 128'(e_data[l]));
        end
      end
      total_retired++;
    end
  end

  task automatic start_test(input bit rand_ready);
    @(posedge clkrst_core_clk);
    arst_n <= 1'b0;
    @(posedge clkrst_core_clk);                       // Pipeline now held in reset
    random_ready = rand_ready;
    prog_len     = 0;
    base_retired = total_retired;
    exp_q.delete();
    for (int r = 0; r < NUM_REGS; r++) begin
      model_regs[r] = '0;
    end
  endtask

  task automatic release_reset();
    repeat (RESET_CYC - 1) @(posedge clkrst_core_clk);
    arst_n <= 1'b1;
  endtask

  task automatic wait_retired();
    int cycles;
    cycles = 0;
    while (total_retired - base_retired < prog_len && cycles < prog_len * 40) begin
      @(posedge clkrst_core_clk);
      cycles++;
    end
    if (total_retired - base_retired < prog_len) begin
      errors++;
      $display("Timed out with %0d of %0d packets retired", total_retired - base_retired,
               prog_len);
    end
  endtask

  task automatic test_reset();
    int cycles;
    cycles = 0;
    start_test(1'b0);
    add_packet(enc_i(1, 0, 5), enc_i(2, 0, -9), 32'h0, 32'h0);
    release_reset();
    while (!ic_valid && cycles < 8) begin
      @(posedge clkrst_core_clk);
      cycles++;
    end
    check("ic_valid", 128'(ic_valid), 128'(1));
    check("ic_paddr", 128'(ic_paddr), 128'(0));       // First request at packet 0
    check("retire_valid", 128'(retire_valid), 128'(0));
    wait_retired();
  endtask

  task automatic test_reg_ops();
    start_test(1'b0);
    add_packet(enc_i(1, 0, -3), enc_i(2, 0, 'h12345), enc_i(3, 0, -77777), 32'h0);
    for (int op = 1; op <= 5; op++) begin
      add_packet(enc_r(OP_W'(op), 4 * op, 1, 2, SH_LSL, (op - 1) * 7),
                 enc_r(OP_W'(op), 4 * op + 1, 2, 1, SH_LSR, op * 5 + 1),
                 enc_r(OP_W'(op), 4 * op + 2, 3, 1, SH_ASR, 31 - op),
                 enc_r(OP_W'(op), 4 * op + 3, 2, 1, SH_ROR, op * 6));
    end
    release_reset();
    wait_retired();
  endtask

  task automatic test_addi();
    start_test(1'b0);
    add_packet(enc_i(5, 0, 131071), enc_i(6, 0, -131072), enc_i(7, 0, -1), enc_i(8, 0, 1234));
    add_packet(enc_i(9, 6, -5), enc_i(10, 7, 17), enc_i(11, 5, -1), enc_i(12, 8, -2000));
    release_reset();
    wait_retired();
  endtask

  // Each packet needs the one before, so every packet waits on the scoreboard
  task automatic test_chain(input bit rand_ready);
    start_test(rand_ready);
    for (int k = 0; k < 8; k++) begin
      add_packet(enc_i(1, 1, k * 37 - 100),
                 enc_r(OP_ADD, 2, 2, 1, SH_LSL, 3),
                 enc_r(OP_XOR, 3, 3, 2, SH_ROR, k * 4 + 1),
                 enc_r(OP_SUB, 4, 1, 3, SH_ASR, 2));
    end
    release_reset();
    wait_retired();
  endtask

  task automatic test_in_packet();
    start_test(1'b0);
    add_packet(enc_i(1, 0, 10), enc_i(2, 0, 20), 32'h0, enc_r(4'hc, 3, 1, 2, SH_LSL, 0));
    add_packet(enc_r(OP_ADD, 1, 2, 1, SH_LSL, 0), enc_r(OP_ADD, 2, 1, 0, SH_LSL, 0),
               enc_i(3, 0, 1), enc_i(3, 0, 2));        // Same rd, lane 3 wins
    add_packet(enc_i(0, 1, 5), enc_r(OP_ADD, 4, 0, 3, SH_LSL, 0),
               enc_r(4'h7, 5, 1, 2, SH_LSL, 0), enc_r(OP_NOP, 6, 1, 2, SH_LSL, 0));
    add_packet(enc_r(OP_ADD, 5, 1, 2, SH_LSL, 0), enc_r(OP_ADD, 6, 3, 4, SH_LSL, 0),
               enc_r(OP_OR, 7, 0, 0, SH_LSL, 0), enc_i(8, 1, -30));
    release_reset();
    wait_retired();
  endtask

  initial begin
    clkrst_core_clk = 1'b0;
    arst_n          = 1'b0;
    ic_ready        = 1'b0;
    ic_packet       = '0;
    random_ready    = 1'b0;
    lfsr            = 32'h052c_7feb;
    errors          = 0;
    total_retired   = 0;
    base_retired    = 0;
    prog_len        = 0;
    fetch_idx       = 0;
    test_reset();
    test_reg_ops();
    test_addi();
    test_chain(1'b0);
    test_chain(1'b1);                                  // Same program, random ic_ready
    test_in_packet();
    $display("Checks done with %0d errors over %0d retired packets", errors, total_retired);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== vliw_core.f ====
rtl/vliw_core_pkg.sv
rtl/vliw_fetch.sv
rtl/vliw_lane_decode.sv
rtl/vliw_issue.sv
rtl/vliw_scoreboard.sv
rtl/vliw_regfile.sv
rtl/vliw_alu.sv
rtl/vliw_execute.sv
rtl/vliw_core.sv
tests/vliw_core_props.sv
tests/vliw_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module vliw_core_tb \
  -f vliw_core.f -o vliw_core_sim \
  && ./obj_dir/vliw_core_sim > sim.log 2>&1 \
  || echo "Build or simulation stopped early"
[ -f sim.log ] && cat sim.log
grep -qx "Test passed" sim.log && echo "Simulation PASS" || { echo "Simulation FAIL"; exit 1; }
